// File: design/xform_pkg.sv
// Fixed-point format, matrix, vector and command types
// Scale-and-saturate and vector element helpers
package xform_pkg;

    localparam int FIX_W     = 18;
    localparam int FRAC_BITS = 12;
    // Holds a sum of four full products
    localparam int ACC_W     = 2 * FIX_W + 2;
    localparam int DIM       = 4;
    localparam int IDX_W     = $clog2(DIM);

    typedef logic signed [FIX_W-1:0] fix_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [IDX_W-1:0]        idx_t;

    localparam fix_t FIX_ONE = fix_t'(1 << FRAC_BITS);
    localparam fix_t FIX_MAX = {1'b0, {(FIX_W-1){1'b1}}};
    localparam fix_t FIX_MIN = {1'b1, {(FIX_W-1){1'b0}}};

    typedef struct packed {
        fix_t x;
        fix_t y;
        fix_t z;
        fix_t w;
    } vec4_t;

    // Row 0 first
    typedef vec4_t [0:DIM-1] mat4_t;

    typedef enum logic [1:0] {
        OP_LOAD      = 2'd0,
        OP_COMPOSE   = 2'd1,
        OP_TRANSFORM = 2'd2
    } xform_op_t;

    typedef struct packed {
        xform_op_t op;
        mat4_t     mat;
        vec4_t     vec;
    } xform_cmd_t;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_ACC  = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

    localparam mat4_t MAT_IDENTITY = '{
        '{x: FIX_ONE, default: '0},
        '{y: FIX_ONE, default: '0},
        '{z: FIX_ONE, default: '0},
        '{w: FIX_ONE, default: '0}
    };

    // Floor by the fraction bits, then clamp to the element range
    function automatic fix_t fix_scale(acc_t a);
        acc_t s;
        s = a >>> FRAC_BITS;
        if (s > acc_t'(FIX_MAX)) begin
            return FIX_MAX;
        end
        if (s < acc_t'(FIX_MIN)) begin
            return FIX_MIN;
        end
        return s[FIX_W-1:0];
    endfunction

    function automatic fix_t vec_get(vec4_t v, idx_t i);
        case (i)
            0: return v.x;
            1: return v.y;
            2: return v.z;
            default: return v.w;
        endcase
    endfunction

endpackage

// File: design/mat_mul.sv
// Multi-cycle 4x4 by 4x4 fixed-point matrix multiplier
// One accumulation cycle per inner index, registered output
`timescale 1ns/1ps

module mat_mul (
    input  logic             clk,
    input  logic             rstn,
    input  xform_pkg::mat4_t i_a,
    input  xform_pkg::mat4_t i_b,
    input  logic             i_dv,
    output xform_pkg::mat4_t o_c,
    output logic             o_done,
    output logic             o_ready
);

    xform_pkg::mul_state_t state;
    xform_pkg::idx_t       idx;
    logic                  start_q;
    logic                  accept;
    xform_pkg::mat4_t      a_q;
    xform_pkg::mat4_t      b_q;
    xform_pkg::acc_t       acc [xform_pkg::DIM][xform_pkg::DIM];

    // Busy from the accepting edge through the done state
    assign o_ready = (state == xform_pkg::MUL_IDLE) && !start_q;
    assign accept  = i_dv && o_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state   <= xform_pkg::MUL_IDLE;
            idx     <= '0;
            start_q <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            start_q <= accept;
            o_done  <= 1'b0;
            case (state)
                xform_pkg::MUL_IDLE: begin
                    if (start_q) begin
                        state <= xform_pkg::MUL_ACC;
                        idx   <= '0;
                    end
                end
                xform_pkg::MUL_ACC: begin
                    idx <= idx + 1'b1;
                    if (idx == xform_pkg::idx_t'(xform_pkg::DIM - 1)) begin
                        state <= xform_pkg::MUL_DONE;
                    end
                end
                xform_pkg::MUL_DONE: begin
                    o_done <= 1'b1;
                    state  <= xform_pkg::MUL_IDLE;
                end
                default: state <= xform_pkg::MUL_IDLE;
            endcase
        end
    end

    // Operand capture and accumulation
    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= i_a;
            b_q <= i_b;
            for (int r = 0; r < xform_pkg::DIM; r++) begin
                for (int c = 0; c < xform_pkg::DIM; c++) begin
                    acc[r][c] <= '0;
                end
            end
        end else if (state == xform_pkg::MUL_ACC) begin
            for (int r = 0; r < xform_pkg::DIM; r++) begin
                for (int c = 0; c < xform_pkg::DIM; c++) begin
                    acc[r][c] <= acc[r][c]
                        + xform_pkg::vec_get(a_q[r], idx)
                        * xform_pkg::vec_get(b_q[idx], xform_pkg::idx_t'(c));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == xform_pkg::MUL_DONE) begin
            for (int r = 0; r < xform_pkg::DIM; r++) begin
                o_c[r].x <= xform_pkg::fix_scale(acc[r][0]);
                o_c[r].y <= xform_pkg::fix_scale(acc[r][1]);
                o_c[r].z <= xform_pkg::fix_scale(acc[r][2]);
                o_c[r].w <= xform_pkg::fix_scale(acc[r][3]);
            end
        end
    end

    // Upstream must respect ready
    a_dv_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        i_dv |-> o_ready);

    a_done_single: assert property (@(posedge clk) disable iff (!rstn)
        o_done |=> !o_done);

endmodule

// File: design/mat_vec_mul.sv
// Multi-cycle 4x4 matrix by vector multiplier
// Four row accumulators stepped over the inner index
`timescale 1ns/1ps

module mat_vec_mul (
    input  logic             clk,
    input  logic             rstn,
    input  xform_pkg::mat4_t i_m,
    input  xform_pkg::vec4_t i_v,
    input  logic             i_dv,
    output xform_pkg::vec4_t o_v,
    output logic             o_done,
    output logic             o_ready
);

    xform_pkg::mul_state_t state;
    xform_pkg::idx_t       idx;
    logic                  accept;
    xform_pkg::mat4_t      m_q;
    xform_pkg::vec4_t      v_q;
    xform_pkg::acc_t       acc [xform_pkg::DIM];

    assign o_ready = (state == xform_pkg::MUL_IDLE);
    assign accept  = i_dv && o_ready;

    // No input delay stage, accumulation starts right after the accept
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= xform_pkg::MUL_IDLE;
            idx    <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                xform_pkg::MUL_IDLE: begin
                    if (accept) begin
                        state <= xform_pkg::MUL_ACC;
                        idx   <= '0;
                    end
                end
                xform_pkg::MUL_ACC: begin
                    idx <= idx + 1'b1;
                    if (idx == xform_pkg::idx_t'(xform_pkg::DIM - 1)) begin
                        state <= xform_pkg::MUL_DONE;
                    end
                end
                xform_pkg::MUL_DONE: begin
                    o_done <= 1'b1;
                    state  <= xform_pkg::MUL_IDLE;
                end
                default: state <= xform_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            m_q <= i_m;
            v_q <= i_v;
            for (int r = 0; r < xform_pkg::DIM; r++) begin
                acc[r] <= '0;
            end
        end else if (state == xform_pkg::MUL_ACC) begin
            for (int r = 0; r < xform_pkg::DIM; r++) begin
                acc[r] <= acc[r]
                    + xform_pkg::vec_get(m_q[r], idx) * xform_pkg::vec_get(v_q, idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == xform_pkg::MUL_DONE) begin
            o_v.x <= xform_pkg::fix_scale(acc[0]);
            o_v.y <= xform_pkg::fix_scale(acc[1]);
            o_v.z <= xform_pkg::fix_scale(acc[2]);
            o_v.w <= xform_pkg::fix_scale(acc[3]);
        end
    end

    // Done only for an operation accepted six edges earlier
    a_done_after_accept: assert property (@(posedge clk) disable iff (!rstn)
        o_done |-> $past(accept, 6));

endmodule

// File: design/xform_sequencer.sv
// Command decoder holding the current transform matrix
// Launches both multipliers and drives upstream ready
`timescale 1ns/1ps

module xform_sequencer (
    input  logic                  clk,
    input  logic                  rstn,
    input  xform_pkg::xform_cmd_t i_cmd,
    input  logic                  i_cmd_dv,
    output logic                  o_ready,
    output xform_pkg::mat4_t      o_mm_a,
    output xform_pkg::mat4_t      o_mm_b,
    output logic                  o_mm_dv,
    input  xform_pkg::mat4_t      i_mm_c,
    input  logic                  i_mm_done,
    output xform_pkg::mat4_t      o_mv_m,
    output xform_pkg::vec4_t      o_mv_v,
    output logic                  o_mv_dv,
    input  xform_pkg::vec4_t      i_mv_v,
    input  logic                  i_mv_done,
    output xform_pkg::vec4_t      o_vec,
    output logic                  o_vec_dv
);

    logic             busy;
    logic             accept;
    xform_pkg::mat4_t cur_mat;

    assign o_ready = !busy;
    assign accept  = i_cmd_dv && !busy;

    // Current matrix always sits on the left
    assign o_mm_a  = cur_mat;
    assign o_mm_b  = i_cmd.mat;
    assign o_mm_dv = accept && (i_cmd.op == xform_pkg::OP_COMPOSE);

    assign o_mv_m  = cur_mat;
    assign o_mv_v  = i_cmd.vec;
    assign o_mv_dv = accept && (i_cmd.op == xform_pkg::OP_TRANSFORM);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy     <= 1'b0;
            cur_mat  <= xform_pkg::MAT_IDENTITY;
            o_vec_dv <= 1'b0;
        end else begin
            o_vec_dv <= i_mv_done;
            if (accept) begin
                case (i_cmd.op)
                    xform_pkg::OP_LOAD:      cur_mat <= i_cmd.mat;
                    xform_pkg::OP_COMPOSE:   busy <= 1'b1;
                    xform_pkg::OP_TRANSFORM: busy <= 1'b1;
                    default: ;
                endcase
            end else if (i_mm_done) begin
                cur_mat <= i_mm_c;
                busy    <= 1'b0;
            end else if (i_mv_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_mv_done) begin
            o_vec <= i_mv_v;
        end
    end

    // One command in flight at a time
    a_cmd_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        i_cmd_dv |-> !busy)
        else $error("command strobe while sequencer busy");

endmodule

// File: design/xform_top.sv
// Geometry transform unit top level
// Sequencer plus matrix and vector multipliers
`timescale 1ns/1ps

module xform_top (
    input  logic                  clk,
    input  logic                  rstn,
    input  xform_pkg::xform_cmd_t i_cmd,
    input  logic                  i_cmd_dv,
    output logic                  o_ready,
    output xform_pkg::vec4_t      o_vec,
    output logic                  o_vec_dv
);

    xform_pkg::mat4_t mm_a;
    xform_pkg::mat4_t mm_b;
    xform_pkg::mat4_t mm_c;
    logic             mm_dv;
    logic             mm_done;
    logic             mm_ready;
    xform_pkg::mat4_t mv_m;
    xform_pkg::vec4_t mv_v_in;
    xform_pkg::vec4_t mv_v_out;
    logic             mv_dv;
    logic             mv_done;
    logic             mv_ready;

    xform_sequencer u_seq (
        .clk       (clk),
        .rstn      (rstn),
        .i_cmd     (i_cmd),
        .i_cmd_dv  (i_cmd_dv),
        .o_ready   (o_ready),
        .o_mm_a    (mm_a),
        .o_mm_b    (mm_b),
        .o_mm_dv   (mm_dv),
        .i_mm_c    (mm_c),
        .i_mm_done (mm_done),
        .o_mv_m    (mv_m),
        .o_mv_v    (mv_v_in),
        .o_mv_dv   (mv_dv),
        .i_mv_v    (mv_v_out),
        .i_mv_done (mv_done),
        .o_vec     (o_vec),
        .o_vec_dv  (o_vec_dv)
    );

    mat_mul u_mat_mul (
        .clk     (clk),
        .rstn    (rstn),
        .i_a     (mm_a),
        .i_b     (mm_b),
        .i_dv    (mm_dv),
        .o_c     (mm_c),
        .o_done  (mm_done),
        .o_ready (mm_ready)
    );

    mat_vec_mul u_mat_vec_mul (
        .clk     (clk),
        .rstn    (rstn),
        .i_m     (mv_m),
        .i_v     (mv_v_in),
        .i_dv    (mv_dv),
        .o_v     (mv_v_out),
        .o_done  (mv_done),
        .o_ready (mv_ready)
    );

    // Sequencer never reports ready while a multiplier is still busy
    a_ready_implies_idle: assert property (@(posedge clk) disable iff (!rstn)
        o_ready |-> (mm_ready && mv_ready));

endmodule

// File: verification/xform_tb.sv
// Testbench for the transform unit top level
// Reference model, checking assertions, watchdog
`timescale 1ns/1ps

module xform_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DLY       = 2;
    localparam int RESET_CYCLES    = 16;
    localparam int N_RANDOM        = 40;
    localparam int N_CMDS          = 10 + N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_CMDS * 10;
    // Q6.12 constants of the model
    localparam int  ONE  = 4096;
    localparam int  FRAC = 12;
    localparam int  VMAX = 131071;
    localparam int  VMIN = -131072;

    logic                  clk;
    logic                  rstn;
    xform_pkg::xform_cmd_t i_cmd;
    logic                  i_cmd_dv;
    logic                  o_ready;
    xform_pkg::vec4_t      o_vec;
    logic                  o_vec_dv;

    integer           seed;
    int               fail_count;
    xform_pkg::mat4_t model_m;
    xform_pkg::vec4_t exp_vec;

    xform_top DUT (
        .clk      (clk),
        .rstn     (rstn),
        .i_cmd    (i_cmd),
        .i_cmd_dv (i_cmd_dv),
        .o_ready  (o_ready),
        .o_vec    (o_vec),
        .o_vec_dv (o_vec_dv)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_fail(string msg);
        fail_count++;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first error");
    endtask

    function automatic int pick_elem(xform_pkg::vec4_t v, int i);
        case (i)
            0: return int'(v.x);
            1: return int'(v.y);
            2: return int'(v.z);
            default: return int'(v.w);
        endcase
    endfunction

    function automatic xform_pkg::vec4_t make_vec(int a, int b, int c, int d);
        xform_pkg::vec4_t v;
        v.x = xform_pkg::fix_t'(a);
        v.y = xform_pkg::fix_t'(b);
        v.z = xform_pkg::fix_t'(c);
        v.w = xform_pkg::fix_t'(d);
        return v;
    endfunction

    function automatic xform_pkg::mat4_t diag_mat(int d);
        xform_pkg::mat4_t m;
        m[0] = make_vec(d, 0, 0, 0);
        m[1] = make_vec(0, d, 0, 0);
        m[2] = make_vec(0, 0, d, 0);
        m[3] = make_vec(0, 0, 0, d);
        return m;
    endfunction

    // Floor toward minus infinity, then clamp
    function automatic int scale_sat(longint s);
        longint q;
        q = s >>> FRAC;
        if (q > VMAX) begin
            return VMAX;
        end
        if (q < VMIN) begin
            return VMIN;
        end
        return int'(q);
    endfunction

    function automatic xform_pkg::vec4_t model_xform(xform_pkg::mat4_t m, xform_pkg::vec4_t v);
        int     e [4];
        longint sum;
        for (int r = 0; r < 4; r++) begin
            sum = 0;
            for (int k = 0; k < 4; k++) begin
                sum += longint'(pick_elem(m[r], k)) * longint'(pick_elem(v, k));
            end
            e[r] = scale_sat(sum);
        end
        return make_vec(e[0], e[1], e[2], e[3]);
    endfunction

    function automatic xform_pkg::mat4_t model_mul(xform_pkg::mat4_t a, xform_pkg::mat4_t b);
        xform_pkg::mat4_t c;
        int               e [4];
        longint           sum;
        for (int r = 0; r < 4; r++) begin
            for (int col = 0; col < 4; col++) begin
                sum = 0;
                for (int k = 0; k < 4; k++) begin
                    sum += longint'(pick_elem(a[r], k)) * longint'(pick_elem(b[k], col));
                end
                e[col] = scale_sat(sum);
            end
            c[r] = make_vec(e[0], e[1], e[2], e[3]);
        end
        return c;
    endfunction

    // Roughly -4.0 to +4.0
    function automatic int rand_fix();
        return $random(seed) % (4 * ONE);
    endfunction

    function automatic xform_pkg::vec4_t rand_vec();
        return make_vec(rand_fix(), rand_fix(), rand_fix(), rand_fix());
    endfunction

    function automatic xform_pkg::mat4_t rand_mat();
        xform_pkg::mat4_t m;
        for (int r = 0; r < 4; r++) begin
            m[r] = rand_vec();
        end
        return m;
    endfunction

    task automatic send_cmd(xform_pkg::xform_cmd_t cmd);
        while (!o_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        i_cmd    = cmd;
        i_cmd_dv = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        i_cmd_dv = 1'b0;
    endtask

    task automatic do_load(xform_pkg::mat4_t m);
        xform_pkg::xform_cmd_t cmd;
        cmd     = '0;
        cmd.op  = xform_pkg::OP_LOAD;
        cmd.mat = m;
        model_m = m;
        send_cmd(cmd);
    endtask

    task automatic do_compose(xform_pkg::mat4_t m);
        xform_pkg::xform_cmd_t cmd;
        cmd     = '0;
        cmd.op  = xform_pkg::OP_COMPOSE;
        cmd.mat = m;
        model_m = model_mul(model_m, m);
        send_cmd(cmd);
    endtask

    // Holds the expected vector until the result has been checked
    task automatic do_transform(xform_pkg::vec4_t v);
        xform_pkg::xform_cmd_t cmd;
        cmd     = '0;
        cmd.op  = xform_pkg::OP_TRANSFORM;
        cmd.vec = v;
        exp_vec = model_xform(model_m, v);
        send_cmd(cmd);
        while (!o_vec_dv) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    a_reset_state: assert property (@(posedge clk) !rstn |=> (o_ready && !o_vec_dv))
        else report_fail($sformatf("FAILED at %0t ns: wrong ready or valid in reset", $time));

    a_vec_value: assert property (@(posedge clk) disable iff (!rstn)
        o_vec_dv |-> (o_vec == exp_vec))
        else report_fail($sformatf("FAILED at %0t ns: o_vec %h, expected %h",
            $time, o_vec, exp_vec));

    a_load_ready: assert property (@(posedge clk) disable iff (!rstn)
        (i_cmd_dv && o_ready && i_cmd.op == xform_pkg::OP_LOAD) |=> o_ready)
        else report_fail($sformatf("FAILED at %0t ns: ready dropped after load", $time));

    a_transform_timing: assert property (@(posedge clk) disable iff (!rstn)
        (i_cmd_dv && o_ready && i_cmd.op == xform_pkg::OP_TRANSFORM)
        |=> (!o_ready && !o_vec_dv) [*6] ##1 (o_ready && o_vec_dv))
        else report_fail($sformatf("FAILED at %0t ns: transform latency or ready wrong", $time));

    a_compose_timing: assert property (@(posedge clk) disable iff (!rstn)
        (i_cmd_dv && o_ready && i_cmd.op == xform_pkg::OP_COMPOSE)
        |=> (!o_ready && !o_vec_dv) [*7] ##1 o_ready)
        else report_fail($sformatf("FAILED at %0t ns: compose latency or ready wrong", $time));

    a_vec_dv_pulse: assert property (@(posedge clk) disable iff (!rstn)
        o_vec_dv |=> !o_vec_dv)
        else report_fail($sformatf("FAILED at %0t ns: o_vec_dv longer than one cycle", $time));

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_fail($sformatf("Timeout: run did not finish within %0d cycles",
            WATCHDOG_CYCLES));
    end

    initial begin
        int sel;
        clk        = 1'b0;
        rstn       = 1'b0;
        i_cmd      = '0;
        i_cmd_dv   = 1'b0;
        seed       = 68;
        fail_count = 0;
        exp_vec    = '0;
        model_m    = diag_mat(ONE);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;

        // Identity after reset
        do_transform(rand_vec());
        do_load(rand_mat());
        do_transform(rand_vec());
        do_load(rand_mat());
        do_compose(rand_mat());
        do_transform(rand_vec());
        // Clamps at both ends
        do_load(diag_mat(31 * ONE));
        do_transform(make_vec(31 * ONE, -31 * ONE, 4 * ONE, 0));
        // One LSB scale, negative halves floor to -1
        do_load(diag_mat(1));
        do_transform(make_vec(-2048, 2048, -1, 4095));

        for (int i = 0; i < N_RANDOM; i++) begin
            sel = {$random(seed)} % 3;
            case (sel)
                0: do_load(rand_mat());
                1: do_compose(rand_mat());
                default: do_transform(rand_vec());
            endcase
        end
        while (!o_ready) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        repeat (2) @(posedge clk);

        if (fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: tb.f
design/xform_pkg.sv
design/mat_mul.sv
design/mat_vec_mul.sv
design/xform_sequencer.sv
design/xform_top.sv
verification/xform_tb.sv

// File: Bender.yml
package:
  name: xform_unit

dependencies: {}

sources:
  - files:
      - design/xform_pkg.sv
      - design/mat_mul.sv
      - design/mat_vec_mul.sv
      - design/xform_sequencer.sv
      - design/xform_top.sv
  - target: test
    files:
      - verification/xform_tb.sv
